// ==== hw/lms_rx_pkg.sv ====
//--------------------------------------------------------------------------
// Shared constants and types for the LMS dual-channel receive path.
// Converter words are unsigned and widened to the sample width by zero
// extension, so the top sample bits are always zero.
// Credit depth must match the buffer depth of the downstream consumer.
//--------------------------------------------------------------------------

package lms_rx_pkg;

   // Transceiver receive channels
   localparam int NUM_CHAN      = 2;

   // Converter bus and sample widths
   localparam int ADC_WIDTH     = 12;
   localparam int SAMPLE_WIDTH  = 14;

   // Consumer buffer depth, also the credit count after reset
   localparam int RX_CREDITS    = 4;
   localparam int CREDIT_WIDTH  = $clog2(RX_CREDITS + 1);

   localparam int CHAN_ID_WIDTH = 1;   // Enough for NUM_CHAN channels

   // One word off the converter bus
   typedef logic [ADC_WIDTH-1:0] adc_word_t;

   // One I or Q sample after extension
   typedef logic [SAMPLE_WIDTH-1:0] sample_t;

   // I sits in the upper half, Q in the lower half
   typedef struct packed
   {
      sample_t i;
      sample_t q;
   } iq_pair_t;

   typedef logic [CHAN_ID_WIDTH-1:0] chan_id_t;

endpackage

// ==== hw/iq_link_if.sv ====
//--------------------------------------------------------------------------
// Link from one receive channel to the credit arbiter.
// The channel holds pair and valid until take; take only with valid.
// overflow is a sticky flag owned by the channel.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

interface iq_link_if;

   lms_rx_pkg::iq_pair_t pair;      // Finished I/Q pair
   logic                 valid;     // Hold register full
   logic                 take;      // Arbiter accepts the pair this cycle
   logic                 overflow;  // A pair was dropped since reset

   // Deinterleaver side
   modport chan (output pair, output valid, output overflow, input take);

   // Arbiter side
   modport arb (input pair, input valid, input overflow, output take);

endinterface

// ==== hw/lms_rx_capture.sv ====
//--------------------------------------------------------------------------
// Input register stage for the transceiver receive buses.
// All pins are sampled on dsp_clk, so the converter clocks are assumed
// to be in phase with it. One cycle from pins to outputs.
// Only the enables are reset; data and select follow the pins.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module lms_rx_capture
(
   input  logic                                     dsp_clk,
   input  logic                                     rst_i,
   input  lms_rx_pkg::adc_word_t                    rx_d_i [lms_rx_pkg::NUM_CHAN],
   input  logic [lms_rx_pkg::NUM_CHAN-1:0]          rx_iqsel_i,
   input  logic [lms_rx_pkg::NUM_CHAN-1:0]          rx_en_i,
   output lms_rx_pkg::adc_word_t                    cap_d_o [lms_rx_pkg::NUM_CHAN],
   output logic [lms_rx_pkg::NUM_CHAN-1:0]          cap_iqsel_o,
   output logic [lms_rx_pkg::NUM_CHAN-1:0]          cap_en_o
);

   // Data and I/Q select, all channels in step
   always_ff @(posedge dsp_clk)
   begin
      for (int c = 0; c < lms_rx_pkg::NUM_CHAN; c++)
      begin
         cap_d_o[c] <= rx_d_i[c];
      end
      cap_iqsel_o <= rx_iqsel_i;
   end

   // Enables gate everything downstream
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         cap_en_o <= '0;
      end
      else
      begin
         cap_en_o <= rx_en_i;
      end
   end

endmodule

// ==== hw/lms_rx_channel.sv ====
//--------------------------------------------------------------------------
// I/Q deinterleaver for one receive channel.
// An I word (select low) waits for the next Q word (select high).
// A Q word without a pending I is ignored; enable low drops the pending I.
// One-pair hold register; a pair finished while it is full is lost and
// sets the sticky overflow flag.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module lms_rx_channel
(
   input  logic                  dsp_clk,
   input  logic                  rst_i,
   input  lms_rx_pkg::adc_word_t cap_d_i,
   input  logic                  cap_iqsel_i,
   input  logic                  cap_en_i,
   iq_link_if.chan               link
);

   lms_rx_pkg::sample_t  word_ext;    // Captured word, zero-extended
   lms_rx_pkg::sample_t  pend_i;
   logic                 pend_valid;
   logic                 pair_done;
   logic                 hold_free;
   lms_rx_pkg::iq_pair_t hold_pair;
   logic                 hold_valid;
   logic                 ovf;

   assign word_ext = {{(lms_rx_pkg::SAMPLE_WIDTH - lms_rx_pkg::ADC_WIDTH){1'b0}}, cap_d_i};

   assign pair_done = cap_en_i & cap_iqsel_i & pend_valid;

   // Free if empty or being taken this cycle
   assign hold_free = ~hold_valid | link.take;

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
         pend_valid <= 1'b0;
      else if (!cap_en_i)
         pend_valid <= 1'b0;            // Gap in the stream
      else if (!cap_iqsel_i)
         pend_valid <= 1'b1;
      else
         pend_valid <= 1'b0;            // Q consumes the I
   end

   always_ff @(posedge dsp_clk)
   begin
      if (cap_en_i && !cap_iqsel_i)
         pend_i <= word_ext;
   end

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         hold_valid <= 1'b0;
         ovf        <= 1'b0;
      end
      else
      begin
         if (pair_done && hold_free)
            hold_valid <= 1'b1;
         else if (link.take)
            hold_valid <= 1'b0;
         if (pair_done && !hold_free)
            ovf <= 1'b1;                // Sticky until reset
      end
   end

   always_ff @(posedge dsp_clk)
   begin
      if (pair_done && hold_free)
         hold_pair <= '{i: pend_i, q: word_ext};
   end

   assign link.pair     = hold_pair;
   assign link.valid    = hold_valid;
   assign link.overflow = ovf;

endmodule

// ==== hw/rx_credit_arbiter.sv ====
//--------------------------------------------------------------------------
// Round-robin merge of the channel links onto one credited output.
// A beat (out_valid_o) follows its take by one cycle and costs a credit,
// which is charged in the cycle after the beat.
// credit_return_i gives back one credit per pulse; the consumer must not
// return more credits than beats it has received.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module rx_credit_arbiter
(
   input  logic                            dsp_clk,
   input  logic                            rst_i,
   iq_link_if.arb                          links [lms_rx_pkg::NUM_CHAN],
   input  logic                            credit_return_i,
   output logic                            out_valid_o,
   output lms_rx_pkg::chan_id_t            out_chan_o,
   output lms_rx_pkg::iq_pair_t            out_pair_o,
   output logic [lms_rx_pkg::NUM_CHAN-1:0] overflow_o
);

   logic [lms_rx_pkg::NUM_CHAN-1:0]     link_valid;
   lms_rx_pkg::iq_pair_t                link_pair [lms_rx_pkg::NUM_CHAN];
   logic [lms_rx_pkg::NUM_CHAN-1:0]     take;
   logic [lms_rx_pkg::CREDIT_WIDTH-1:0] credit_cnt;
   logic                                credit_ok;
   logic                                grant;
   lms_rx_pkg::chan_id_t                grant_chan;
   lms_rx_pkg::chan_id_t                last_chan;   // Last channel served

   genvar c;
   generate
      for (c = 0; c < lms_rx_pkg::NUM_CHAN; c++)
      begin : g_link
         assign link_valid[c]  = links[c].valid;
         assign link_pair[c]   = links[c].pair;
         assign overflow_o[c]  = links[c].overflow;
         assign links[c].take  = take[c];
      end
   endgenerate

   // The beat on the output still holds a credit not yet charged
   assign credit_ok = credit_cnt > lms_rx_pkg::CREDIT_WIDTH'(out_valid_o);

   always_comb
   begin
      int idx;
      grant      = 1'b0;
      grant_chan = last_chan;
      take       = '0;
      // Search starts one past the last channel served
      for (int k = 1; k <= lms_rx_pkg::NUM_CHAN; k++)
      begin
         idx = (int'(last_chan) + k) % lms_rx_pkg::NUM_CHAN;
         if (!grant && link_valid[idx])
         begin
            grant      = 1'b1;
            grant_chan = lms_rx_pkg::chan_id_t'(idx);
         end
      end
      grant = grant & credit_ok;
      if (grant)
         take[grant_chan] = 1'b1;
   end

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         out_valid_o <= 1'b0;
         last_chan   <= lms_rx_pkg::chan_id_t'(lms_rx_pkg::NUM_CHAN - 1);  // Channel 0 first
         credit_cnt  <= lms_rx_pkg::CREDIT_WIDTH'(lms_rx_pkg::RX_CREDITS);
      end
      else
      begin
         out_valid_o <= grant;
         if (grant)
            last_chan <= grant_chan;
         // Use and return may land in the same cycle
         credit_cnt <= credit_cnt - lms_rx_pkg::CREDIT_WIDTH'(out_valid_o)
                       + lms_rx_pkg::CREDIT_WIDTH'(credit_return_i);
      end
   end

   // Output payload
   always_ff @(posedge dsp_clk)
   begin
      if (grant)
      begin
         out_chan_o <= grant_chan;
         out_pair_o <= link_pair[grant_chan];
      end
   end

endmodule

// ==== hw/lms_rx_top.sv ====
//--------------------------------------------------------------------------
// Receive interface for a dual LMS-style RF transceiver.
// Each channel delivers interleaved 12-bit I and Q words with a select
// line and an enable; pairs of both channels leave as one credited stream
// tagged with the channel number.
// Single clock domain: all pins are sampled on dsp_clk.
// Shortest path from a Q word on the pins to out_valid_o is 3 cycles.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module lms_rx_top
(
   input  logic                            dsp_clk,
   input  logic                            rst_i,
   input  lms_rx_pkg::adc_word_t           rx_d_i [lms_rx_pkg::NUM_CHAN],
   input  logic [lms_rx_pkg::NUM_CHAN-1:0] rx_iqsel_i,
   input  logic [lms_rx_pkg::NUM_CHAN-1:0] rx_en_i,
   input  logic                            credit_return_i,
   output logic                            out_valid_o,
   output lms_rx_pkg::chan_id_t            out_chan_o,
   output lms_rx_pkg::iq_pair_t            out_pair_o,
   output logic [lms_rx_pkg::NUM_CHAN-1:0] overflow_o
);

   lms_rx_pkg::adc_word_t           cap_d [lms_rx_pkg::NUM_CHAN];
   logic [lms_rx_pkg::NUM_CHAN-1:0] cap_iqsel;
   logic [lms_rx_pkg::NUM_CHAN-1:0] cap_en;

   iq_link_if link [lms_rx_pkg::NUM_CHAN] ();   // One per channel

   lms_rx_capture u_capture
   (
      .dsp_clk     (dsp_clk),
      .rst_i       (rst_i),
      .rx_d_i      (rx_d_i),
      .rx_iqsel_i  (rx_iqsel_i),
      .rx_en_i     (rx_en_i),
      .cap_d_o     (cap_d),
      .cap_iqsel_o (cap_iqsel),
      .cap_en_o    (cap_en)
   );

   genvar c;
   generate
      for (c = 0; c < lms_rx_pkg::NUM_CHAN; c++)
      begin : g_chan
         lms_rx_channel u_channel
         (
            .dsp_clk     (dsp_clk),
            .rst_i       (rst_i),
            .cap_d_i     (cap_d[c]),
            .cap_iqsel_i (cap_iqsel[c]),
            .cap_en_i    (cap_en[c]),
            .link        (link[c])
         );
      end
   endgenerate

   rx_credit_arbiter u_arbiter
   (
      .dsp_clk         (dsp_clk),
      .rst_i           (rst_i),
      .links           (link),
      .credit_return_i (credit_return_i),
      .out_valid_o     (out_valid_o),
      .out_chan_o      (out_chan_o),
      .out_pair_o      (out_pair_o),
      .overflow_o      (overflow_o)
   );

endmodule

// ==== verif/rx_sva.sv ====
//--------------------------------------------------------------------------
// Assertions on the credit arbiter, bound into every instance of it.
// Sampled on dsp_clk and disabled while reset is high.
// fail_count is read at the end of the run for the final verdict.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module rx_sva
(
   input logic                                dsp_clk,
   input logic                                rst_i,
   input logic                                out_valid_i,
   input logic [lms_rx_pkg::CREDIT_WIDTH-1:0] credit_cnt_i,
   input logic [lms_rx_pkg::NUM_CHAN-1:0]     take_i,
   input logic [lms_rx_pkg::NUM_CHAN-1:0]     link_valid_i
);

   int fail_count = 0;

   // A beat still holds its uncharged credit
   beat_needs_credit: assert property (@(posedge dsp_clk) disable iff (rst_i)
      out_valid_i |-> credit_cnt_i != '0)
   else
   begin
      $error("output beat sent while the credit count is zero");
      fail_count++;
   end

   take_needs_valid: assert property (@(posedge dsp_clk) disable iff (rst_i)
      (take_i & ~link_valid_i) == '0)
   else
   begin
      $error("take raised on a link without valid");
      fail_count++;
   end

   credit_in_range: assert property (@(posedge dsp_clk) disable iff (rst_i)
      credit_cnt_i <= lms_rx_pkg::CREDIT_WIDTH'(lms_rx_pkg::RX_CREDITS))
   else
   begin
      $error("credit count above the consumer depth");
      fail_count++;
   end

endmodule

bind rx_credit_arbiter rx_sva u_sva
(
   .dsp_clk      (dsp_clk),
   .rst_i        (rst_i),
   .out_valid_i  (out_valid_o),
   .credit_cnt_i (credit_cnt),
   .take_i       (take),
   .link_valid_i (link_valid)
);

// ==== verif/rx_checker.sv ====
//--------------------------------------------------------------------------
// Scoreboard for lms_rx_top. Expected pairs are queued per channel and
// every beat must match the head of its channel's queue.
// Ports are sampled at the falling edge, where they are stable.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module rx_checker
(
   input logic                            dsp_clk,
   input logic                            rst_i,
   input logic                            out_valid_i,
   input lms_rx_pkg::chan_id_t            out_chan_i,
   input lms_rx_pkg::iq_pair_t            out_pair_i,
   input logic [lms_rx_pkg::NUM_CHAN-1:0] overflow_i
);

   lms_rx_pkg::iq_pair_t exp_q [lms_rx_pkg::NUM_CHAN][$];
   string                test_name = "none";
   int                   test_beats = 0;
   int                   test_errors = 0;
   int                   total_errors = 0;
   int                   tests_run = 0;
   int                   tests_failed = 0;

   // Words are unsigned, widened with zeros to the sample width
   function automatic lms_rx_pkg::iq_pair_t expected_pair(input lms_rx_pkg::adc_word_t i_word,
                                                          input lms_rx_pkg::adc_word_t q_word);
      lms_rx_pkg::iq_pair_t p;
      p.i = lms_rx_pkg::sample_t'(i_word);
      p.q = lms_rx_pkg::sample_t'(q_word);
      return p;
   endfunction

   task automatic expect_pair(input int c, input lms_rx_pkg::adc_word_t i_word,
                              input lms_rx_pkg::adc_word_t q_word);
      exp_q[c].push_back(expected_pair(i_word, q_word));
   endtask

   function automatic int pending();
      int n;
      n = 0;
      for (int c = 0; c < lms_rx_pkg::NUM_CHAN; c++)
         n += exp_q[c].size();
      return n;
   endfunction

   task automatic report_error(input string msg);
      $display("ERROR %s: %s", test_name, msg);
      test_errors++;
      total_errors++;
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("FAIL %s: %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
         test_errors++;
         total_errors++;
      end
   endtask

   task automatic check_overflow(input logic [lms_rx_pkg::NUM_CHAN-1:0] expected);
      check_value("overflow_o", 32'(expected), 32'(overflow_i));
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_beats  = 0;
      test_errors = 0;
   endtask

   task automatic end_test();
      $display("%-14s %s, %0d beats, %0d errors", test_name,
               (test_errors == 0) ? "ok" : "failed", test_beats, test_errors);
      tests_run++;
      if (test_errors != 0)
         tests_failed++;
      for (int c = 0; c < lms_rx_pkg::NUM_CHAN; c++)
         exp_q[c].delete();           // No carry-over into the next test
   endtask

   task automatic print_summary(input int assert_fails);
      $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
               tests_run, tests_failed, total_errors, assert_fails);
   endtask

   // Every beat is matched against its channel's oldest expected pair
   always @(negedge dsp_clk)
   begin
      int c;
      if (!rst_i && out_valid_i)
      begin
         c = int'(out_chan_i);
         test_beats++;
         if (exp_q[c].size() == 0)
            report_error($sformatf("beat on channel %0d with no pair outstanding", c));
         else
            check_value($sformatf("channel %0d pair", c), 32'(exp_q[c].pop_front()),
                        32'(out_pair_i));
      end
   end

endmodule

// ==== verif/tb_lms_rx.sv ====
//--------------------------------------------------------------------------
// Testbench for lms_rx_top. Inputs change 1 ns after the rising edge.
// Data words come from a 32-bit Fibonacci LFSR with a fixed seed.
// The consumer returns one credit per cycle unless credits are held.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_lms_rx;

   logic                            dsp_clk = 1'b0;
   logic                            rst_i;
   lms_rx_pkg::adc_word_t           rx_d [lms_rx_pkg::NUM_CHAN];
   logic [lms_rx_pkg::NUM_CHAN-1:0] rx_iqsel;
   logic [lms_rx_pkg::NUM_CHAN-1:0] rx_en;
   logic                            credit_return = 1'b0;
   logic                            out_valid;
   lms_rx_pkg::chan_id_t            out_chan;
   lms_rx_pkg::iq_pair_t            out_pair;
   logic [lms_rx_pkg::NUM_CHAN-1:0] overflow;

   logic [31:0]                     lfsr = 32'h785d_fc2b;
   logic                            hold_credits = 1'b0;
   int                              owed_credits = 0;
   lms_rx_pkg::adc_word_t           nxt_d [lms_rx_pkg::NUM_CHAN];   // Words for the next cycle
   logic [lms_rx_pkg::NUM_CHAN-1:0] nxt_sel;
   logic [lms_rx_pkg::NUM_CHAN-1:0] nxt_en;
   logic [lms_rx_pkg::NUM_CHAN-1:0] nxt_keep;
   logic [lms_rx_pkg::NUM_CHAN-1:0] pend;                           // Model of the pending I
   lms_rx_pkg::adc_word_t           pend_i [lms_rx_pkg::NUM_CHAN];
   int                              test_len [5] = '{20, 35, 35, 45, 90};   // Cycles per test

   always #5 dsp_clk = ~dsp_clk;

   lms_rx_top UUT
   (
      .dsp_clk (dsp_clk), .rst_i (rst_i), .rx_d_i (rx_d), .rx_iqsel_i (rx_iqsel),
      .rx_en_i (rx_en), .credit_return_i (credit_return), .out_valid_o (out_valid),
      .out_chan_o (out_chan), .out_pair_o (out_pair), .overflow_o (overflow)
   );

   rx_checker u_checker
   (
      .dsp_clk (dsp_clk), .rst_i (rst_i), .out_valid_i (out_valid), .out_chan_i (out_chan),
      .out_pair_i (out_pair), .overflow_i (overflow)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_word(output lms_rx_pkg::adc_word_t w);
      for (int b = 0; b < lms_rx_pkg::ADC_WIDTH; b++)
      begin
         lfsr = lfsr_next(lfsr);          // One step per bit
         w    = {w[lms_rx_pkg::ADC_WIDTH-2:0], lfsr[0]};
      end
   endtask

   task automatic plan_word(input int c, input logic sel, input logic keep);
      rand_word(nxt_d[c]);
      nxt_sel[c]  = sel;
      nxt_en[c]   = 1'b1;
      nxt_keep[c] = keep;
   endtask

   // Applies the planned words and queues the pairs they complete
   task automatic clock_words();
      @(posedge dsp_clk);
      #1;
      for (int c = 0; c < lms_rx_pkg::NUM_CHAN; c++)
      begin
         rx_d[c]     = nxt_d[c];
         rx_iqsel[c] = nxt_sel[c];
         rx_en[c]    = nxt_en[c];
         if (!nxt_en[c])
            pend[c] = 1'b0;
         else if (!nxt_sel[c])
         begin
            pend[c]   = 1'b1;
            pend_i[c] = nxt_d[c];
         end
         else if (pend[c])
         begin
            pend[c] = 1'b0;
            if (nxt_keep[c])
               u_checker.expect_pair(c, pend_i[c], nxt_d[c]);
         end
         nxt_en[c] = 1'b0;                // Idle unless planned again
      end
   endtask

   task automatic send_pair(input int c, input logic keep);
      plan_word(c, 1'b0, keep);
      clock_words();
      plan_word(c, 1'b1, keep);
      clock_words();
   endtask

   task automatic idle(input int n);
      repeat (n) clock_words();
   endtask

   task automatic drain(input int limit);
      int n;
      n = 0;
      while (u_checker.pending() != 0 && n < limit)
      begin
         clock_words();
         n++;
      end
      if (u_checker.pending() != 0)
         u_checker.report_error($sformatf("%0d beats still missing after %0d cycles",
                                          u_checker.pending(), limit));
      idle(6);                            // Catch late extra beats
   endtask

   // Consumer credit model
   always @(negedge dsp_clk)
   begin
      if (!rst_i && out_valid)
         owed_credits++;
   end

   always @(posedge dsp_clk)
   begin
      #1;
      credit_return = !hold_credits && owed_credits > 0;
      if (credit_return)
         owed_credits--;
   end

   initial
   begin
      int total;
      total = 4 + 100;                    // Reset plus margin
      foreach (test_len[t])
         total += test_len[t];
      #(total * 10);
      $display("Watchdog expired after %0d cycles, tests did not finish", total);
      $display("** FAIL **");
      $finish;
   end

   initial
   begin
      rst_i    = 1'b1;
      rx_iqsel = '0;
      rx_en    = '0;
      nxt_sel  = '0;
      nxt_en   = '0;
      nxt_keep = '0;
      pend     = '0;
      for (int c = 0; c < lms_rx_pkg::NUM_CHAN; c++)
      begin
         rx_d[c]   = '0;
         nxt_d[c]  = '0;
         pend_i[c] = '0;
      end
      repeat (4) @(posedge dsp_clk);
      #1;
      rst_i = 1'b0;

      u_checker.begin_test("reset_idle");
      repeat (20)
      begin
         clock_words();
         u_checker.check_overflow('0);
      end
      u_checker.end_test();

      u_checker.begin_test("single_pairs");
      send_pair(0, 1'b1);
      plan_word(0, 1'b1, 1'b1);           // Q with no I before it
      clock_words();
      send_pair(1, 1'b1);
      send_pair(0, 1'b1);
      drain(20);
      u_checker.end_test();

      u_checker.begin_test("enable_gap");
      plan_word(0, 1'b0, 1'b1);
      clock_words();
      clock_words();                      // Enable low drops the pending I
      plan_word(0, 1'b1, 1'b1);
      clock_words();
      send_pair(1, 1'b1);
      drain(20);
      u_checker.end_test();

      u_checker.begin_test("dual_stream");
      for (int k = 0; k <= 16; k++)
      begin
         if (k < 16)
            plan_word(0, k[0], 1'b1);
         if (k > 0)
            plan_word(1, !k[0], 1'b1);    // Channel 1 one word behind
         clock_words();
      end
      drain(20);
      u_checker.check_overflow('0);
      u_checker.end_test();

      u_checker.begin_test("credit_stall");
      while (owed_credits != 0)
         clock_words();
      idle(2);
      hold_credits = 1'b1;
      repeat (2)
      begin
         send_pair(0, 1'b1);
         idle(3);
         send_pair(1, 1'b1);
         idle(3);
      end
      send_pair(0, 1'b1);                 // Both of these wait in the hold registers
      idle(3);
      send_pair(1, 1'b1);
      idle(3);
      send_pair(0, 1'b0);                 // Hold full, pair lost
      idle(8);
      u_checker.check_value("beats without credits", lms_rx_pkg::RX_CREDITS,
                            u_checker.test_beats);
      hold_credits = 1'b0;
      drain(30);
      u_checker.check_overflow(lms_rx_pkg::NUM_CHAN'(1));   // Only channel 0 overflowed
      u_checker.end_test();

      u_checker.print_summary(UUT.u_arbiter.u_sva.fail_count);
      if (u_checker.total_errors == 0 && UUT.u_arbiter.u_sva.fail_count == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// ==== all.f ====
hw/lms_rx_pkg.sv
hw/iq_link_if.sv
hw/lms_rx_capture.sv
hw/lms_rx_channel.sv
hw/rx_credit_arbiter.sv
hw/lms_rx_top.sv
verif/rx_sva.sv
verif/rx_checker.sv
verif/tb_lms_rx.sv
